/* sim/mem_link_patterns.txt */
// columns: op lane len 0 payload, one 32-bit hex word per packet
// op 1 lone lane packet, 2 lanes at once, 3 core packet to lane, 4 core packet to a lane switched off
10200100
11100200
12300300
13000400
20400a00
21100b00
22200c00
23700d00
20000e00
21300f00
30200500
31500600
32000700
33300800
31400900
40100990

/* mem_link.f */
hdl/mem_link_pkg.sv
hdl/link_token_rx.sv
hdl/wh_concentrator.sv
hdl/link_token_tx.sv
hdl/link_cfg_apb.sv
hdl/mem_link_top.sv
sim/mem_link_checker.sv
sim/mem_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mem_link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mem_link_tb -f mem_link.f -o Vmem_link_tb

out=$(./obj_dir/Vmem_link_tb)
echo "$out"

if echo "$out" | grep -q "Simulation passed"; then
  exit 0
else
  exit 1
fi

/* sim/mem_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_link_tb;

  localparam int MAX_RECS = 32;

  logic                                              core_clk;
  logic                                              rst_n;
  mem_link_pkg::lane_mask_t                          lane_v_i;
  mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0] lane_data_i;
  mem_link_pkg::lane_mask_t                          lane_token_o;
  mem_link_pkg::lane_mask_t                          lane_v_o;
  mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0] lane_data_o;
  mem_link_pkg::lane_mask_t                          lane_token_i;
  logic                                              core_v_o;
  mem_link_pkg::flit_t                               core_data_o;
  logic                                              core_ready_i;
  logic                                              core_v_i;
  mem_link_pkg::flit_t                               core_data_i;
  logic                                              core_ready_o;
  mem_link_pkg::apb_addr_t                           paddr;
  logic                                              psel;
  logic                                              penable;
  logic                                              pwrite;
  mem_link_pkg::apb_data_t                           pwdata;
  mem_link_pkg::apb_data_t                           prdata;
  logic                                              pready;
  logic                                              pslverr;

  logic [31:0]         pats [MAX_RECS];
  int                  n_rx_pkts;
  int                  n_tx_pkts;
  int                  total_flits;
  int                  limit;
  int                  cycles;
  int                  seed;
  mem_link_pkg::flit_t lane_q [mem_link_pkg::NUM_LANES][$];
  mem_link_pkg::flit_t core_q [$];
  int                  send_cred [mem_link_pkg::NUM_LANES];
  int                  half [mem_link_pkg::NUM_LANES];
  int                  pend_tok [mem_link_pkg::NUM_LANES];
  logic                withhold;
  logic                core_rdy_seen;
  mem_link_pkg::apb_data_t rd;
  logic                err;
  mem_link_pkg::cid_t  off_lane;

  mem_link_top dut
    (.core_clk_i(core_clk), .rst_n_i(rst_n)
    ,.lane_v_i(lane_v_i), .lane_data_i(lane_data_i), .lane_token_o(lane_token_o)
    ,.lane_v_o(lane_v_o), .lane_data_o(lane_data_o), .lane_token_i(lane_token_i)
    ,.core_v_o(core_v_o), .core_data_o(core_data_o), .core_ready_i(core_ready_i)
    ,.core_v_i(core_v_i), .core_data_i(core_data_i), .core_ready_o(core_ready_o)
    ,.paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite)
    ,.pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

  mem_link_checker chk
    (.core_clk_i(core_clk)
    ,.lane_in_v_i(lane_v_i), .lane_in_token_i(lane_token_o)
    ,.lane_out_v_i(lane_v_o), .lane_out_data_i(lane_data_o), .lane_out_token_i(lane_token_i)
    ,.core_v_i(core_v_o), .core_data_i(core_data_o), .core_ready_i(core_ready_i)
    );

  initial
  begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  // header carries lane and length and the body counts up from the payload.
  task automatic queue_packet(input logic [31:0] rec);
    mem_link_pkg::cid_t  lane;
    mem_link_pkg::len_t  len;
    mem_link_pkg::flit_t pay;
    mem_link_pkg::flit_t f;
    lane = rec[25:24];
    len  = rec[22:20];
    pay  = rec[15:0];
    for (int i = 0; i <= int'(len); i++)
    begin
      if (i == 0)
        f = {pay[15:5], lane, len};
      else
        f = pay + mem_link_pkg::flit_t'(i - 1);
      if (rec[31:28] == 4'h1 || rec[31:28] == 4'h2)
      begin
        lane_q[lane].push_back(f);
        chk.expect_rx(int'(lane), f);
      end
      else
      begin
        core_q.push_back(f);
        chk.expect_tx(int'(lane), f);
      end
    end
  endtask

  function automatic int tokens_owed();
    int n;
    n = 0;
    for (int l = 0; l < mem_link_pkg::NUM_LANES; l++)
      n = n + pend_tok[l];
    return n;
  endfunction

  task automatic wait_drained();
    while (chk.pending() != 0 || tokens_owed() != 0)
      @(posedge core_clk);
    repeat (4) @(posedge core_clk);
  endtask

  task automatic apb_write(input mem_link_pkg::apb_addr_t a, input mem_link_pkg::apb_data_t d);
    @(posedge core_clk);
    #10;
    paddr  = a;
    pwdata = d;
    pwrite = 1'b1;
    psel   = 1'b1;
    @(posedge core_clk);
    #10;
    penable = 1'b1;
    @(negedge core_clk);
    chk.compare_value("pready_o", 32'd1, 32'(pready));
    @(posedge core_clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input mem_link_pkg::apb_addr_t a,
                          output mem_link_pkg::apb_data_t d, output logic e);
    @(posedge core_clk);
    #10;
    paddr  = a;
    pwrite = 1'b0;
    psel   = 1'b1;
    @(posedge core_clk);
    #10;
    penable = 1'b1;
    @(negedge core_clk);
    d = prdata;
    e = pslverr;
    chk.compare_value("pready_o", 32'd1, 32'(pready));
    @(posedge core_clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // lane senders, lane receivers and the core source drive just after the edge.
  initial
  begin
    wait (rst_n);
    forever
    begin
      @(posedge core_clk);
      #10;
      for (int l = 0; l < mem_link_pkg::NUM_LANES; l++)
      begin
        if (lane_token_o[l])
          send_cred[l] = send_cred[l] + mem_link_pkg::TOKEN_DECIMATION;
        lane_v_i[l] = 1'b0;
        if (lane_q[l].size() > 0 && send_cred[l] > 0)
        begin
          lane_data_i[l] = lane_q[l].pop_front();
          lane_v_i[l]    = 1'b1;
          send_cred[l]--;
        end
        if (lane_v_o[l])
        begin
          half[l]++;
          if (half[l] == mem_link_pkg::TOKEN_DECIMATION)
          begin
            half[l] = 0;
            pend_tok[l]++;
          end
        end
        lane_token_i[l] = 1'b0;
        if (!withhold && pend_tok[l] > 0)
        begin
          lane_token_i[l] = 1'b1;
          pend_tok[l]--;
        end
      end
      if (core_v_i && core_rdy_seen)
        void'(core_q.pop_front());
      core_v_i     = (core_q.size() > 0);
      core_data_i  = (core_q.size() > 0) ? core_q[0] : '0;
      core_ready_i = (($random(seed) & 3) != 0);
    end
  end

  initial
  begin
    core_rdy_seen = 1'b0;
    forever
    begin
      @(negedge core_clk);
      core_rdy_seen = core_ready_o;
    end
  end

  initial
  begin
    cycles = 0;
    limit  = 0;
    wait (limit != 0);
    while (cycles < limit)
    begin
      @(posedge core_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d flits still expected", cycles, chk.pending());
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    rst_n        = 1'b0;
    lane_v_i     = '0;
    lane_data_i  = '0;
    lane_token_i = '0;
    core_ready_i = 1'b0;
    core_v_i     = 1'b0;
    core_data_i  = '0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    withhold     = 1'b0;
    seed         = 32'hbbb7;
    off_lane     = '0;
    for (int l = 0; l < mem_link_pkg::NUM_LANES; l++)
    begin
      send_cred[l] = mem_link_pkg::FIFO_DEPTH;
      half[l]      = 0;
      pend_tok[l]  = 0;
    end
    for (int i = 0; i < MAX_RECS; i++)
      pats[i] = '0;
    $readmemh("sim/mem_link_patterns.txt", pats);

    n_rx_pkts   = 0;
    n_tx_pkts   = 0;
    total_flits = 0;
    for (int i = 0; i < MAX_RECS; i++)
    begin
      if (pats[i][31:28] == 4'h1 || pats[i][31:28] == 4'h2)
        n_rx_pkts++;
      if (pats[i][31:28] == 4'h3 || pats[i][31:28] == 4'h4)
        n_tx_pkts++;
      if (pats[i][31:28] != 4'h0)
        total_flits = total_flits + int'(pats[i][22:20]) + 1;
    end
    limit = total_flits * 40 + 500;

    repeat (10) @(posedge core_clk);
    #10;
    rst_n = 1'b1;

    apb_read(mem_link_pkg::REG_CTRL, rd, err);
    chk.compare_value("REG_CTRL", 32'((1 << mem_link_pkg::NUM_LANES) - 1), rd);
    chk.compare_value("pslverr_o", 32'd0, 32'(err));
    chk.end_test("control register after reset");

    for (int i = 0; i < MAX_RECS; i++)
    begin
      if (pats[i][31:28] == 4'h1)
      begin
        queue_packet(pats[i]);
        wait_drained();
      end
    end
    chk.end_test("single lane packets");

    for (int i = 0; i < MAX_RECS; i++)
      if (pats[i][31:28] == 4'h2)
        queue_packet(pats[i]);
    wait_drained();
    chk.end_test("concurrent lanes");

    withhold = 1'b1; // far receivers keep their tokens for now.
    for (int i = 0; i < MAX_RECS; i++)
      if (pats[i][31:28] == 4'h3)
        queue_packet(pats[i]);
    repeat (30) @(posedge core_clk);
    chk.compare_value("lane_v_o[1] flits without tokens", 32'(mem_link_pkg::FIFO_DEPTH),
                      32'(chk.tx_flit_count(1)));
    withhold = 1'b0;
    wait_drained();
    chk.end_test("core packets to lanes");

    chk.check_tokens();
    chk.end_test("token returns");

    apb_read(mem_link_pkg::REG_RX_PKTS, rd, err);
    chk.compare_value("REG_RX_PKTS", 32'(n_rx_pkts), rd);
    apb_read(4'hc, rd, err);
    chk.compare_value("pslverr_o", 32'd1, 32'(err));

    for (int i = 0; i < MAX_RECS; i++)
    begin
      if (pats[i][31:28] == 4'h4)
      begin
        off_lane = pats[i][25:24];
        apb_write(mem_link_pkg::REG_CTRL, 32'(4'hf & ~(4'h1 << off_lane)));
        chk.set_lane_off(int'(off_lane), 1'b1);
        half[off_lane] = 0;
        queue_packet(pats[i]);
        repeat (20) @(posedge core_clk);
        chk.compare_value("stalled core flits", 32'(int'(pats[i][22:20]) + 1),
                          32'(core_q.size()));
        apb_read(mem_link_pkg::REG_CTRL, rd, err);
        chk.compare_value("REG_CTRL", 32'(4'hf & ~(4'h1 << off_lane)), rd);
        chk.set_lane_off(int'(off_lane), 1'b0);
        apb_write(mem_link_pkg::REG_CTRL, 32'hf);
        wait_drained();
      end
    end
    apb_read(mem_link_pkg::REG_TX_PKTS, rd, err);
    chk.compare_value("REG_TX_PKTS", 32'(n_tx_pkts), rd);
    chk.end_test("register block");

    chk.close_report();
    if (chk.error_count() == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/mem_link_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_link_checker
  (input  wire                                                 core_clk_i
  ,input  wire mem_link_pkg::lane_mask_t                       lane_in_v_i
  ,input  wire mem_link_pkg::lane_mask_t                       lane_in_token_i
  ,input  wire mem_link_pkg::lane_mask_t                       lane_out_v_i
  ,input  wire mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0] lane_out_data_i
  ,input  wire mem_link_pkg::lane_mask_t                       lane_out_token_i
  ,input  wire                                                 core_v_i
  ,input  wire mem_link_pkg::flit_t                            core_data_i
  ,input  wire                                                 core_ready_i
  );

  mem_link_pkg::flit_t      exp_rx_q [mem_link_pkg::NUM_LANES][$];
  mem_link_pkg::flit_t      exp_tx_q [mem_link_pkg::NUM_LANES][$];
  int                       rx_flits [mem_link_pkg::NUM_LANES];
  int                       rx_toks [mem_link_pkg::NUM_LANES];
  int                       tx_flits [mem_link_pkg::NUM_LANES];
  int                       tx_toks [mem_link_pkg::NUM_LANES];
  mem_link_pkg::lane_mask_t lane_off;
  int                       errors;
  int                       test_start;
  int                       tests;
  logic                     in_pkt;
  mem_link_pkg::cid_t       cur_lane;
  mem_link_pkg::len_t       remain;

  initial
  begin
    for (int l = 0; l < mem_link_pkg::NUM_LANES; l++)
    begin
      rx_flits[l] = 0;
      rx_toks[l]  = 0;
      tx_flits[l] = 0;
      tx_toks[l]  = 0;
    end
    lane_off   = '0;
    errors     = 0;
    test_start = 0;
    tests      = 0;
    in_pkt     = 1'b0;
    cur_lane   = '0;
    remain     = '0;
  end

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic expect_rx(input int l, input mem_link_pkg::flit_t f);
    exp_rx_q[l].push_back(f);
  endtask

  task automatic expect_tx(input int l, input mem_link_pkg::flit_t f);
    exp_tx_q[l].push_back(f);
  endtask

  // far side credits restart at full when a lane is switched off.
  task automatic set_lane_off(input int l, input logic off);
    lane_off[l] = off;
    tx_flits[l] = 0;
    tx_toks[l]  = 0;
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int l = 0; l < mem_link_pkg::NUM_LANES; l++)
      n = n + exp_rx_q[l].size() + exp_tx_q[l].size();
    return n;
  endfunction

  function automatic int tx_flit_count(input int l);
    return tx_flits[l];
  endfunction

  task automatic check_tokens();
    for (int l = 0; l < mem_link_pkg::NUM_LANES; l++)
      compare_value($sformatf("lane_token_o[%0d] pulses", l), 32'(rx_flits[l] / 2),
                    32'(rx_toks[l]));
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_start)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: failed with %0d errors", tests, name, errors - test_start);
    test_start = errors;
  endtask

  task automatic close_report();
    if (pending() != 0)
      note_failure($sformatf("%0d expected flits never arrived", pending()));
    $display("tests run %0d, checks failed %0d", tests, errors);
  endtask

  function automatic int error_count();
    return errors;
  endfunction

  // sampled mid-cycle, where every port is settled.
  always @(negedge core_clk_i)
  begin
    for (int l = 0; l < mem_link_pkg::NUM_LANES; l++)
    begin
      if (lane_in_v_i[l])
        rx_flits[l]++;
      if (lane_in_token_i[l])
        rx_toks[l]++;
      if (lane_out_v_i[l])
      begin
        if (lane_off[l])
          note_failure($sformatf("disabled lane %0d sent a flit", l));
        tx_flits[l]++;
        if (tx_flits[l] - mem_link_pkg::TOKEN_DECIMATION * tx_toks[l]
            > mem_link_pkg::FIFO_DEPTH)
          note_failure($sformatf("lane %0d sent more flits than its credits allow", l));
        if (exp_tx_q[l].size() == 0)
          note_failure($sformatf("unexpected flit on lane_data_o[%0d]", l));
        else
          compare_value($sformatf("lane_data_o[%0d]", l), 32'(exp_tx_q[l].pop_front()),
                        32'(lane_out_data_i[l]));
      end
      if (lane_out_token_i[l])
        tx_toks[l]++;
    end

    if (core_v_i && core_ready_i)
    begin
      if (!in_pkt)
      begin
        cur_lane = core_data_i[mem_link_pkg::CID_LSB +: 2]; // header names its lane.
        remain   = core_data_i[mem_link_pkg::LEN_LSB +: 3];
        in_pkt   = (remain != '0);
      end
      else
      begin
        remain = remain - mem_link_pkg::len_t'(1);
        in_pkt = (remain != '0);
      end
      if (exp_rx_q[cur_lane].size() == 0)
        note_failure("unexpected flit on core_data_o");
      else
        compare_value("core_data_o", 32'(exp_rx_q[cur_lane].pop_front()), 32'(core_data_i));
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_link_top
  (input  wire                                                 core_clk_i
  ,input  wire                                                 rst_n_i

  ,input  wire mem_link_pkg::lane_mask_t                       lane_v_i
  ,input  wire mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0] lane_data_i
  ,output mem_link_pkg::lane_mask_t                            lane_token_o

  ,output mem_link_pkg::lane_mask_t                            lane_v_o
  ,output mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0]   lane_data_o
  ,input  wire mem_link_pkg::lane_mask_t                       lane_token_i

  ,output logic                                                core_v_o
  ,output mem_link_pkg::flit_t                                 core_data_o
  ,input  wire                                                 core_ready_i

  ,input  wire                                                 core_v_i
  ,input  wire mem_link_pkg::flit_t                            core_data_i
  ,output logic                                                core_ready_o

  ,input  wire mem_link_pkg::apb_addr_t                        paddr_i
  ,input  wire                                                 psel_i
  ,input  wire                                                 penable_i
  ,input  wire                                                 pwrite_i
  ,input  wire mem_link_pkg::apb_data_t                        pwdata_i
  ,output mem_link_pkg::apb_data_t                             prdata_o
  ,output logic                                                pready_o
  ,output logic                                                pslverr_o
  );

  mem_link_pkg::lane_mask_t                            lane_en_lo;
  mem_link_pkg::lane_mask_t                            rx_v_lo;
  mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0]   rx_data_lo;
  mem_link_pkg::lane_mask_t                            rx_ready_li;
  mem_link_pkg::lane_mask_t                            tx_v_li;
  mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0]   tx_data_li;
  mem_link_pkg::lane_mask_t                            tx_ready_lo;
  logic                                                rx_pkt_done_lo;
  logic                                                tx_pkt_done_lo;

  for (genvar i = 0; i < mem_link_pkg::NUM_LANES; i++)
  begin: rx
    link_token_rx rx_lane
      (.core_clk_i  (core_clk_i)
      ,.rst_n_i     (rst_n_i)
      ,.lane_en_i   (lane_en_lo[i])
      ,.lane_v_i    (lane_v_i[i])
      ,.lane_data_i (lane_data_i[i])
      ,.lane_token_o(lane_token_o[i])
      ,.v_o         (rx_v_lo[i])
      ,.data_o      (rx_data_lo[i])
      ,.ready_i     (rx_ready_li[i])
      );
  end

  wh_concentrator conc
    (.core_clk_i   (core_clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.rx_v_i       (rx_v_lo)
    ,.rx_data_i    (rx_data_lo)
    ,.rx_ready_o   (rx_ready_li)
    ,.core_v_o     (core_v_o)
    ,.core_data_o  (core_data_o)
    ,.core_ready_i (core_ready_i)
    ,.core_v_i     (core_v_i)
    ,.core_data_i  (core_data_i)
    ,.core_ready_o (core_ready_o)
    ,.tx_v_o       (tx_v_li)
    ,.tx_data_o    (tx_data_li)
    ,.tx_ready_i   (tx_ready_lo)
    ,.rx_pkt_done_o(rx_pkt_done_lo)
    ,.tx_pkt_done_o(tx_pkt_done_lo)
    );

  for (genvar i = 0; i < mem_link_pkg::NUM_LANES; i++)
  begin: tx
    link_token_tx tx_lane
      (.core_clk_i  (core_clk_i)
      ,.rst_n_i     (rst_n_i)
      ,.lane_en_i   (lane_en_lo[i])
      ,.v_i         (tx_v_li[i])
      ,.data_i      (tx_data_li[i])
      ,.ready_o     (tx_ready_lo[i])
      ,.lane_v_o    (lane_v_o[i])
      ,.lane_data_o (lane_data_o[i])
      ,.lane_token_i(lane_token_i[i])
      );
  end

  link_cfg_apb cfg
    (.core_clk_i   (core_clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.paddr_i      (paddr_i)
    ,.psel_i       (psel_i)
    ,.penable_i    (penable_i)
    ,.pwrite_i     (pwrite_i)
    ,.pwdata_i     (pwdata_i)
    ,.prdata_o     (prdata_o)
    ,.pready_o     (pready_o)
    ,.pslverr_o    (pslverr_o)
    ,.lane_en_o    (lane_en_lo)
    ,.rx_pkt_done_i(rx_pkt_done_lo)
    ,.tx_pkt_done_i(tx_pkt_done_lo)
    );

endmodule

`default_nettype wire

/* hdl/link_cfg_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module link_cfg_apb
  (input  wire                              core_clk_i
  ,input  wire                              rst_n_i

  ,input  wire mem_link_pkg::apb_addr_t     paddr_i
  ,input  wire                              psel_i
  ,input  wire                              penable_i
  ,input  wire                              pwrite_i
  ,input  wire mem_link_pkg::apb_data_t     pwdata_i
  ,output mem_link_pkg::apb_data_t          prdata_o
  ,output logic                             pready_o
  ,output logic                             pslverr_o

  ,output mem_link_pkg::lane_mask_t         lane_en_o
  ,input  wire                              rx_pkt_done_i
  ,input  wire                              tx_pkt_done_i
  );

  mem_link_pkg::lane_mask_t ctrl_r;
  mem_link_pkg::count_t     rx_pkts_r;
  mem_link_pkg::count_t     tx_pkts_r;
  logic                     access;
  logic                     mapped;

  assign access = psel_i & penable_i;
  assign mapped = (paddr_i == mem_link_pkg::REG_CTRL)
                | (paddr_i == mem_link_pkg::REG_RX_PKTS)
                | (paddr_i == mem_link_pkg::REG_TX_PKTS);

  // zero wait states.
  assign pready_o  = penable_i;
  assign pslverr_o = access & ~mapped;
  assign lane_en_o = ctrl_r;

  always_comb
  begin
    prdata_o = '0;
    if (access && !pwrite_i)
    begin
      case (paddr_i)
        mem_link_pkg::REG_CTRL:    prdata_o = mem_link_pkg::apb_data_t'(ctrl_r);
        mem_link_pkg::REG_RX_PKTS: prdata_o = mem_link_pkg::apb_data_t'(rx_pkts_r);
        mem_link_pkg::REG_TX_PKTS: prdata_o = mem_link_pkg::apb_data_t'(tx_pkts_r);
        default:                   prdata_o = '0;
      endcase
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      ctrl_r    <= '1; // all lanes on.
      rx_pkts_r <= '0;
      tx_pkts_r <= '0;
    end
    else
    begin
      if (access && pwrite_i && paddr_i == mem_link_pkg::REG_CTRL)
        ctrl_r <= pwdata_i[mem_link_pkg::NUM_LANES-1:0];
      // counters wrap.
      if (rx_pkt_done_i)
        rx_pkts_r <= rx_pkts_r + mem_link_pkg::count_t'(1);
      if (tx_pkt_done_i)
        tx_pkts_r <= tx_pkts_r + mem_link_pkg::count_t'(1);
    end
  end

endmodule

`default_nettype wire

/* hdl/link_token_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module link_token_tx
  (input  wire                       core_clk_i
  ,input  wire                       rst_n_i
  ,input  wire                       lane_en_i

  ,input  wire                       v_i
  ,input  wire mem_link_pkg::flit_t  data_i
  ,output logic                      ready_o

  ,output logic                      lane_v_o
  ,output mem_link_pkg::flit_t       lane_data_o
  ,input  wire                       lane_token_i
  );

  mem_link_pkg::credit_t credit_r;
  mem_link_pkg::credit_t credit_nxt;
  logic                  fire;

  assign ready_o = lane_en_i & (credit_r != '0);
  assign fire    = v_i & ready_o;

  // refill on token, spend on accept, never above the far fifo depth.
  always_comb
  begin
    int credit_sum;
    credit_sum = int'(credit_r) - int'(fire);
    if (lane_token_i)
      credit_sum = credit_sum + mem_link_pkg::TOKEN_DECIMATION;
    if (credit_sum > mem_link_pkg::FIFO_DEPTH)
      credit_nxt = mem_link_pkg::credit_t'(mem_link_pkg::FIFO_DEPTH);
    else
      credit_nxt = mem_link_pkg::credit_t'(credit_sum);
  end

  always_ff @(posedge core_clk_i)
  begin
    if (fire)
      lane_data_o <= data_i;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i || !lane_en_i)
    begin
      credit_r <= mem_link_pkg::credit_t'(mem_link_pkg::FIFO_DEPTH);
      lane_v_o <= 1'b0;
    end
    else
    begin
      credit_r <= credit_nxt;
      lane_v_o <= fire; // one cycle behind the accept.
    end
  end

endmodule

`default_nettype wire

/* hdl/wh_concentrator.sv */
`timescale 1ns/1ps
`default_nettype none

module wh_concentrator
  (input  wire                                                 core_clk_i
  ,input  wire                                                 rst_n_i

  ,input  wire mem_link_pkg::lane_mask_t                       rx_v_i
  ,input  wire mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0] rx_data_i
  ,output mem_link_pkg::lane_mask_t                            rx_ready_o

  ,output logic                                                core_v_o
  ,output mem_link_pkg::flit_t                                 core_data_o
  ,input  wire                                                 core_ready_i

  ,input  wire                                                 core_v_i
  ,input  wire mem_link_pkg::flit_t                            core_data_i
  ,output logic                                                core_ready_o

  ,output mem_link_pkg::lane_mask_t                            tx_v_o
  ,output mem_link_pkg::flit_t [mem_link_pkg::NUM_LANES-1:0]   tx_data_o
  ,input  wire mem_link_pkg::lane_mask_t                       tx_ready_i

  ,output logic                                                rx_pkt_done_o
  ,output logic                                                tx_pkt_done_o
  );

  function automatic mem_link_pkg::len_t hdr_len(input mem_link_pkg::flit_t f);
    return f[mem_link_pkg::LEN_LSB +: $bits(mem_link_pkg::len_t)];
  endfunction

  function automatic mem_link_pkg::cid_t hdr_cid(input mem_link_pkg::flit_t f);
    return f[mem_link_pkg::CID_LSB +: $bits(mem_link_pkg::cid_t)];
  endfunction

  // header with zero length, or the final body flit.
  function automatic logic pkt_last(input logic hdr, input mem_link_pkg::len_t cnt,
                                    input mem_link_pkg::flit_t f);
    return hdr ? (hdr_len(f) == '0) : (cnt == mem_link_pkg::len_t'(1));
  endfunction

  mem_link_pkg::conc_state_e arb_state_r;
  mem_link_pkg::cid_t        last_r;
  mem_link_pkg::cid_t        pick;
  logic                      pick_v;
  logic                      arb_hdr_r;
  mem_link_pkg::len_t        arb_cnt_r;
  logic                      core_fire;

  mem_link_pkg::conc_state_e rt_state_r;
  mem_link_pkg::cid_t        sel_r;
  logic                      rt_hdr_r;
  mem_link_pkg::len_t        rt_cnt_r;
  logic                      core_in_fire;

  // round robin search begins after the last winner.
  always_comb
  begin
    mem_link_pkg::cid_t idx;
    pick   = last_r;
    pick_v = 1'b0;
    for (int i = 1; i <= mem_link_pkg::NUM_LANES; i++)
    begin
      idx = mem_link_pkg::cid_t'(int'(last_r) + i);
      if (!pick_v && rx_v_i[idx])
      begin
        pick   = idx;
        pick_v = 1'b1;
      end
    end
  end

  assign core_v_o      = (arb_state_r == mem_link_pkg::BODY) & rx_v_i[last_r];
  assign core_data_o   = rx_data_i[last_r];
  assign core_fire     = core_v_o & core_ready_i;
  assign rx_pkt_done_o = core_fire & pkt_last(arb_hdr_r, arb_cnt_r, core_data_o);

  always_comb
  begin
    rx_ready_o = '0;
    if (arb_state_r == mem_link_pkg::BODY)
      rx_ready_o[last_r] = core_ready_i;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      arb_state_r <= mem_link_pkg::IDLE;
      last_r      <= mem_link_pkg::cid_t'(mem_link_pkg::NUM_LANES - 1); // lane 0 goes first.
      arb_hdr_r   <= 1'b0;
      arb_cnt_r   <= '0;
    end
    else if (arb_state_r == mem_link_pkg::IDLE)
    begin
      if (pick_v)
      begin
        last_r      <= pick;
        arb_hdr_r   <= 1'b1;
        arb_state_r <= mem_link_pkg::BODY;
      end
    end
    else if (core_fire)
    begin
      if (rx_pkt_done_o)
        arb_state_r <= mem_link_pkg::IDLE;
      arb_hdr_r <= 1'b0;
      arb_cnt_r <= arb_hdr_r ? hdr_len(core_data_o) : arb_cnt_r - mem_link_pkg::len_t'(1);
    end
  end

  // the reply path steers a header in its own cycle.
  assign core_ready_o  = (rt_state_r == mem_link_pkg::BODY) & tx_ready_i[sel_r];
  assign core_in_fire  = core_v_i & core_ready_o;
  assign tx_pkt_done_o = core_in_fire & pkt_last(rt_hdr_r, rt_cnt_r, core_data_i);
  assign tx_data_o     = {mem_link_pkg::NUM_LANES{core_data_i}};

  always_comb
  begin
    tx_v_o = '0;
    if (rt_state_r == mem_link_pkg::BODY)
      tx_v_o[sel_r] = core_v_i;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      rt_state_r <= mem_link_pkg::IDLE;
      sel_r      <= '0;
      rt_hdr_r   <= 1'b0;
      rt_cnt_r   <= '0;
    end
    else if (rt_state_r == mem_link_pkg::IDLE)
    begin
      if (core_v_i)
      begin
        sel_r      <= hdr_cid(core_data_i);
        rt_hdr_r   <= 1'b1;
        rt_state_r <= mem_link_pkg::BODY;
      end
    end
    else if (core_in_fire)
    begin
      if (tx_pkt_done_o)
        rt_state_r <= mem_link_pkg::IDLE;
      rt_hdr_r <= 1'b0;
      rt_cnt_r <= rt_hdr_r ? hdr_len(core_data_i) : rt_cnt_r - mem_link_pkg::len_t'(1);
    end
  end

endmodule

`default_nettype wire

/* hdl/link_token_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module link_token_rx
  (input  wire                       core_clk_i
  ,input  wire                       rst_n_i
  ,input  wire                       lane_en_i

  ,input  wire                       lane_v_i
  ,input  wire mem_link_pkg::flit_t  lane_data_i
  ,output logic                      lane_token_o

  ,output logic                      v_o
  ,output mem_link_pkg::flit_t       data_o
  ,input  wire                       ready_i
  );

  mem_link_pkg::flit_t     mem_r [mem_link_pkg::FIFO_DEPTH];
  mem_link_pkg::fifo_ptr_t wr_ptr_r;
  mem_link_pkg::fifo_ptr_t rd_ptr_r;
  mem_link_pkg::credit_t   occ_r;
  mem_link_pkg::dec_cnt_t  dec_r;
  logic                    enq;
  logic                    deq;
  logic                    group_done;

  // sender spends credits, so a full fifo should never see a flit.
  assign enq = lane_en_i & lane_v_i
             & (occ_r != mem_link_pkg::credit_t'(mem_link_pkg::FIFO_DEPTH));
  assign deq = v_o & ready_i;

  assign group_done = deq
                    & (dec_r == mem_link_pkg::dec_cnt_t'(mem_link_pkg::TOKEN_DECIMATION - 1));

  assign v_o    = lane_en_i & (occ_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge core_clk_i)
  begin
    if (enq)
    begin
      mem_r[wr_ptr_r] <= lane_data_i;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i || !lane_en_i)
    begin
      wr_ptr_r     <= '0;
      rd_ptr_r     <= '0;
      occ_r        <= '0;
      dec_r        <= '0;
      lane_token_o <= 1'b0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= wr_ptr_r + mem_link_pkg::fifo_ptr_t'(1);
      if (deq)
        rd_ptr_r <= rd_ptr_r + mem_link_pkg::fifo_ptr_t'(1);

      case ({enq, deq})
        2'b10:   occ_r <= occ_r + mem_link_pkg::credit_t'(1);
        2'b01:   occ_r <= occ_r - mem_link_pkg::credit_t'(1);
        default: occ_r <= occ_r;
      endcase

      // one token per group of dequeued flits.
      if (deq)
        dec_r <= group_done ? '0 : dec_r + mem_link_pkg::dec_cnt_t'(1);
      lane_token_o <= group_done;
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_link_pkg.sv */
`default_nettype none

package mem_link_pkg;

  localparam int NUM_LANES        = 4;
  localparam int FIFO_DEPTH       = 4; // flits per lane receiver.
  localparam int TOKEN_DECIMATION = 2; // flits per token.

  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int DEC_CNT_W  = $clog2(TOKEN_DECIMATION);

  // wormhole header layout.
  localparam int LEN_LSB  = 0;
  localparam int CID_LSB  = 3;
  localparam int CORD_LSB = 5;

  typedef logic [15:0]          flit_t;
  typedef logic [2:0]           len_t;  // body flits after the header.
  typedef logic [1:0]           cid_t;  // lane id.
  typedef logic [3:0]           cord_t; // destination, passed through.
  typedef logic [NUM_LANES-1:0] lane_mask_t;
  typedef logic [2:0]           credit_t;
  typedef logic [15:0]          count_t;

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [DEC_CNT_W-1:0]  dec_cnt_t;

  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  localparam apb_addr_t REG_CTRL    = 4'h0;
  localparam apb_addr_t REG_RX_PKTS = 4'h4;
  localparam apb_addr_t REG_TX_PKTS = 4'h8;

  // shared by the arbiter and the router.
  typedef enum logic
  {
    IDLE,
    BODY
  } conc_state_e;

endpackage

`default_nettype wire
